/* dv/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic o_clk,
    output logic o_rst
);

initial begin
    o_clk = 1'b0;
    forever begin
        #5 o_clk = ~o_clk;
    end
end

// reset spans four rising edges
initial begin
    o_rst = 1'b1;
    repeat (4) @(posedge o_clk);
    #1;
    o_rst = 1'b0;
end

endmodule

`default_nettype wire

/* dv/tcp_stream_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module tcp_stream_tb;

localparam int TIMEOUT = 60;
localparam logic [7:0] F_FIN = 8'd1 << tcp_pkg::FLAG_FIN;
localparam logic [7:0] F_SYN = 8'd1 << tcp_pkg::FLAG_SYN;
localparam logic [7:0] F_RST = 8'd1 << tcp_pkg::FLAG_RST;
localparam logic [7:0] F_ACK = 8'd1 << tcp_pkg::FLAG_ACK;

logic        clk;
logic        rst;
logic        enable;
logic        open_req;
logic        close_req;
logic [15:0] src_port;
logic [15:0] dst_port;
logic [31:0] isn;
logic        rx_valid;
logic        rx_ready;
logic [31:0] rx_seq;
logic [31:0] rx_ack;
logic [7:0]  rx_flags;
logic [15:0] rx_window;
logic        tx_valid;
logic        tx_ready;
logic [15:0] tx_src_port;
logic [15:0] tx_dst_port;
logic [31:0] tx_seq;
logic [31:0] tx_ack;
logic [7:0]  tx_flags;
logic [15:0] tx_window;
tcp_pkg::tcp_state_t state;

logic [31:0] lcg_seed = 32'd37258;
logic [15:0] cur_src;
logic [15:0] cur_dst;
logic [31:0] cur_isn;
logic [31:0] cur_peer;
int err_cnt = 0;
int tests_run = 0;
int tests_failed = 0;
int cyc = 0;

tb_clk_gen u_clk_gen (
    .o_clk (clk),
    .o_rst (rst)
);

tcp_stream dut0 (
    .i_clk          (clk),
    .i_rst          (rst),
    .i_enable       (enable),
    .i_open         (open_req),
    .i_close        (close_req),
    .i_src_port     (src_port),
    .i_dst_port     (dst_port),
    .i_isn          (isn),
    .i_rx_valid     (rx_valid),
    .o_rx_ready     (rx_ready),
    .i_rx_seq       (rx_seq),
    .i_rx_ack       (rx_ack),
    .i_rx_flags     (rx_flags),
    .i_rx_window    (rx_window),
    .o_tx_valid     (tx_valid),
    .i_tx_ready     (tx_ready),
    .o_tx_src_port  (tx_src_port),
    .o_tx_dst_port  (tx_dst_port),
    .o_tx_seq       (tx_seq),
    .o_tx_ack       (tx_ack),
    .o_tx_flags     (tx_flags),
    .o_tx_window    (tx_window),
    .o_state        (state)
);

always @(posedge clk) begin
    cyc <= cyc + 1;
end

function automatic logic [31:0] lcg_next();
    lcg_seed = lcg_seed * 32'd1103515245 + 32'd12345;
    return lcg_seed;
endfunction

task automatic tick();
    @(posedge clk);
    #1;
endtask

task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
        $display("[FAIL] t=%0t %s expected 0x%0h got 0x%0h", $time, name, exp, act);
        err_cnt++;
    end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        $display("[FAIL] t=%0t %s expected %b got %b", $time, name, exp, act);
        err_cnt++;
    end
endtask

task automatic check_state(input tcp_pkg::tcp_state_t exp);
    if (state !== exp) begin
        $display("[FAIL] t=%0t o_state expected %s got %s", $time, exp.name(), state.name());
        err_cnt++;
    end
endtask

task automatic check_hdr(input logic [31:0] seq, input logic [31:0] ack, input logic [7:0] flags);
    check_field("o_tx_seq", seq, tx_seq);
    check_field("o_tx_ack", ack, tx_ack);
    check_field("o_tx_flags", flags, tx_flags);
    check_field("o_tx_window", tcp_pkg::RX_WINDOW, tx_window);
    check_field("o_tx_src_port", cur_src, tx_src_port);
    check_field("o_tx_dst_port", cur_dst, tx_dst_port);
endtask

task automatic wait_hdr(input int limit, output bit found);
    int n;
    n = 0;
    while (!tx_valid && n < limit) begin
        tick();
        n++;
    end
    found = tx_valid;
endtask

task automatic release_hdr();
    tx_ready = 1'b1;
    tick();
    tx_ready = 1'b0;
endtask

// waits for a header, checks it, keeps it stalled for hold cycles, then takes it
task automatic expect_hdr(input logic [31:0] seq, input logic [31:0] ack,
                          input logic [7:0] flags, input int hold);
    bit found;
    wait_hdr(TIMEOUT, found);
    if (!found) begin
        $display("ERROR at %0t: no transmit header within %0d cycles", $time, TIMEOUT);
        err_cnt++;
    end else begin
        check_hdr(seq, ack, flags);
        repeat (hold) begin
            tick();
            check_bit("o_tx_valid", 1'b1, tx_valid);
            check_hdr(seq, ack, flags);
        end
        release_hdr();
    end
endtask

task automatic expect_no_hdr(input int limit);
    bit found;
    wait_hdr(limit, found);
    if (found) begin
        $display("ERROR at %0t: unexpected transmit header with flags 0x%0h", $time, tx_flags);
        err_cnt++;
        release_hdr();
    end
endtask

task automatic wait_state(input tcp_pkg::tcp_state_t exp, input int limit);
    int n;
    n = 0;
    while (state !== exp && n < limit) begin
        tick();
        n++;
    end
    check_state(exp);
endtask

task automatic send_seg(input logic [31:0] seq, input logic [31:0] ack, input logic [7:0] flags);
    int n;
    rx_seq = seq;
    rx_ack = ack;
    rx_flags = flags;
    rx_valid = 1'b1;
    n = 0;
    while (!rx_ready && n < TIMEOUT) begin
        tick();
        n++;
    end
    if (!rx_ready) begin
        $display("ERROR at %0t: receive header was never accepted", $time);
        err_cnt++;
    end
    // ready is a register output, so the handshake completes on this edge
    tick();
    rx_valid = 1'b0;
endtask

task automatic go_closed();
    enable = 1'b0;
    tick();
    tick();
    enable = 1'b1;
    check_state(tcp_pkg::ST_CLOSED);
endtask

// fresh ports and sequence numbers, then SYN / SYN+ACK / ACK
task automatic open_conn(input bit bad_ack);
    logic [31:0] ports;
    ports = lcg_next();
    cur_src = ports[15:0];
    cur_dst = ports[31:16];
    cur_isn = lcg_next();
    cur_peer = lcg_next();
    src_port = cur_src;
    dst_port = cur_dst;
    isn = cur_isn;
    open_req = 1'b1;
    tick();
    open_req = 1'b0;
    expect_hdr(cur_isn, 32'd0, F_SYN, 0);
    check_state(tcp_pkg::ST_SYN_SENT);
    if (bad_ack) begin
        send_seg(cur_peer, cur_isn + 32'd7, F_SYN | F_ACK);
        expect_no_hdr(20);
        check_state(tcp_pkg::ST_SYN_SENT);
    end
    send_seg(cur_peer, cur_isn + 32'd1, F_SYN | F_ACK);
    expect_hdr(cur_isn + 32'd1, cur_peer + 32'd1, F_ACK, 0);
    wait_state(tcp_pkg::ST_ESTABLISHED, TIMEOUT);
endtask

task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (err_cnt == errs_before) begin
        $display("test %s: ok", name);
    end else begin
        tests_failed++;
        $display("test %s: failed", name);
    end
endtask

task automatic test_reset();
    int e0;
    e0 = err_cnt;
    check_state(tcp_pkg::ST_CLOSED);
    check_bit("o_tx_valid", 1'b0, tx_valid);
    check_bit("o_rx_ready", 1'b1, rx_ready);
    enable = 1'b0;
    open_req = 1'b1;
    tick();
    open_req = 1'b0;
    expect_no_hdr(20);
    check_state(tcp_pkg::ST_CLOSED);
    enable = 1'b1;
    finish_test("reset", e0);
endtask

task automatic test_active_open();
    int e0;
    e0 = err_cnt;
    go_closed();
    open_conn(1'b0);
    finish_test("active_open", e0);
endtask

task automatic test_bad_ack();
    int e0;
    e0 = err_cnt;
    go_closed();
    open_conn(1'b1);
    finish_test("bad_ack", e0);
endtask

task automatic test_active_close();
    int e0;
    int t0;
    e0 = err_cnt;
    go_closed();
    open_conn(1'b0);
    close_req = 1'b1;
    tick();
    close_req = 1'b0;
    expect_hdr(cur_isn + 32'd1, cur_peer + 32'd1, F_FIN | F_ACK, 5);
    check_state(tcp_pkg::ST_FIN_WAIT_1);
    send_seg(cur_peer + 32'd1, cur_isn + 32'd2, F_ACK);
    wait_state(tcp_pkg::ST_FIN_WAIT_2, TIMEOUT);
    send_seg(cur_peer + 32'd1, cur_isn + 32'd2, F_FIN | F_ACK);
    wait_state(tcp_pkg::ST_TIME_WAIT, TIMEOUT);
    t0 = cyc;
    expect_hdr(cur_isn + 32'd2, cur_peer + 32'd2, F_ACK, 0);
    wait_state(tcp_pkg::ST_CLOSED, TIMEOUT);
    if (cyc - t0 < tcp_pkg::TIME_WAIT_CYCLES) begin
        $display("ERROR at %0t: TIME_WAIT lasted only %0d cycles", $time, cyc - t0);
        err_cnt++;
    end
    finish_test("active_close", e0);
endtask

task automatic test_passive_close();
    int e0;
    e0 = err_cnt;
    go_closed();
    open_conn(1'b0);
    send_seg(cur_peer + 32'd1, cur_isn + 32'd1, F_FIN | F_ACK);
    expect_hdr(cur_isn + 32'd1, cur_peer + 32'd2, F_FIN | F_ACK, 0);
    check_state(tcp_pkg::ST_LAST_ACK);
    send_seg(cur_peer + 32'd2, cur_isn + 32'd2, F_ACK);
    wait_state(tcp_pkg::ST_CLOSED, TIMEOUT);
    finish_test("passive_close", e0);
endtask

task automatic test_peer_reset();
    int e0;
    e0 = err_cnt;
    go_closed();
    open_conn(1'b0);
    send_seg(cur_peer + 32'd1, cur_isn + 32'd1, F_RST);
    wait_state(tcp_pkg::ST_CLOSED, TIMEOUT);
    expect_no_hdr(20);
    // second open with new ports and ISN
    open_conn(1'b0);
    go_closed();
    finish_test("peer_reset", e0);
endtask

initial begin
    int n;
    enable = 1'b1;
    open_req = 1'b0;
    close_req = 1'b0;
    src_port = '0;
    dst_port = '0;
    isn = '0;
    rx_valid = 1'b0;
    rx_seq = '0;
    rx_ack = '0;
    rx_flags = '0;
    rx_window = 16'h2000;
    tx_ready = 1'b0;
    n = 0;
    while (rst !== 1'b0 && n < 20) begin
        tick();
        n++;
    end
    if (rst !== 1'b0) begin
        $display("ERROR at %0t: reset was never released", $time);
        err_cnt++;
    end
    test_reset();
    test_active_open();
    test_bad_ack();
    test_active_close();
    test_passive_close();
    test_peer_reset();
    $display("tests %0d, failed %0d, check errors %0d", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
        $display("RESULT: PASS");
    end else begin
        $display("RESULT: FAIL");
    end
    $finish;
end

endmodule

`default_nettype wire

/* sources.f */
verilog/tcp_pkg.sv
verilog/tcp_state_manager.sv
verilog/tcp_tx_ctrl.sv
verilog/tcp_rx_ctrl.sv
verilog/tcp_hdr_gen.sv
verilog/tcp_stream.sv
dv/tb_clk_gen.sv
dv/tcp_stream_tb.sv

/* verilog/tcp_hdr_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tcp_hdr_gen (
    input  wire          i_clk,
    input  wire          i_rst,

    input  wire [15:0]   i_src_port,
    input  wire [15:0]   i_dst_port,

    input  wire [31:0]   i_seq,
    input  wire [7:0]    i_flags,
    input  wire          i_hdr_valid,
    output logic         o_hdr_ready,

    input  wire [31:0]   i_rcv_nxt,

    output logic [15:0]  o_tx_src_port,
    output logic [15:0]  o_tx_dst_port,
    output logic [31:0]  o_tx_seq,
    output logic [31:0]  o_tx_ack,
    output logic [7:0]   o_tx_flags,
    output logic [15:0]  o_tx_window,
    output logic         o_tx_valid,
    input  wire          i_tx_ready
);

logic        tx_valid_q;
logic        hdr_fire;
logic [31:0] ack_sel;

// refill allowed in the cycle the held header leaves
assign o_hdr_ready = !tx_valid_q || i_tx_ready;
assign hdr_fire    = i_hdr_valid && o_hdr_ready;

// ack field only meaningful with ACK set
assign ack_sel = i_flags[tcp_pkg::FLAG_ACK] ? i_rcv_nxt : 32'd0;

assign o_tx_valid  = tx_valid_q;
assign o_tx_window = tcp_pkg::RX_WINDOW;

always_ff @(posedge i_clk) begin
    if (i_rst) begin
        tx_valid_q <= 1'b0;
    end else if (hdr_fire) begin
        tx_valid_q <= 1'b1;
    end else if (i_tx_ready) begin
        tx_valid_q <= 1'b0;
    end
end

always_ff @(posedge i_clk) begin
    if (hdr_fire) begin
        o_tx_src_port <= i_src_port;
        o_tx_dst_port <= i_dst_port;
        o_tx_seq      <= i_seq;
        o_tx_ack      <= ack_sel;
        o_tx_flags    <= i_flags;
    end
end

endmodule

`default_nettype wire

/* verilog/tcp_pkg.sv */
`default_nettype none

package tcp_pkg;

    // connection states
    typedef enum logic [2:0] {
        ST_CLOSED,
        ST_SYN_SENT,
        ST_ESTABLISHED,
        ST_FIN_WAIT_1,
        ST_FIN_WAIT_2,
        ST_TIME_WAIT,
        ST_LAST_ACK
    } tcp_state_t;

    // classified received segments
    typedef enum logic [2:0] {
        MSG_SYNACK,
        MSG_ACK,
        MSG_FIN,
        MSG_RST,
        MSG_BAD
    } rx_msg_t;

    // transmit requests, TX_FIN carries ACK as well
    typedef enum logic [1:0] {
        TX_SYN,
        TX_ACK,
        TX_FIN
    } tx_req_t;

    // bit positions in the 8-bit flags field
    localparam int FLAG_FIN = 0;
    localparam int FLAG_SYN = 1;
    localparam int FLAG_RST = 2;
    localparam int FLAG_ACK = 4;

    localparam logic [15:0] RX_WINDOW = 16'h4000;

    localparam int TIME_WAIT_CYCLES = 16;
    localparam int TW_CNT_W = $clog2(TIME_WAIT_CYCLES + 1);
    localparam logic [TW_CNT_W-1:0] TW_LAST = TW_CNT_W'(TIME_WAIT_CYCLES - 1);

endpackage

`default_nettype wire

/* verilog/tcp_rx_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module tcp_rx_ctrl (
    input  wire                      i_clk,
    input  wire                      i_rst,

    input  wire [31:0]               i_rx_seq,
    input  wire [31:0]               i_rx_ack,
    input  wire [7:0]                i_rx_flags,
    input  wire [15:0]               i_rx_window,
    input  wire                      i_rx_valid,
    output logic                     o_rx_ready,

    input  wire [31:0]               i_snd_nxt,

    output tcp_pkg::rx_msg_t         o_msg,
    output logic                     o_msg_valid,
    input  wire                      i_msg_ready,

    output logic [31:0]              o_rcv_nxt
);

tcp_pkg::rx_msg_t msg_q;
tcp_pkg::rx_msg_t msg_d;
logic msg_valid_q;

logic [31:0] rcv_nxt_q;

logic rx_fire;
logic msg_fire;
logic f_syn;
logic f_ack;
logic f_fin;
logic f_rst;
logic ack_ok;
logic seq_ok;

// one-entry message register
assign o_rx_ready = !msg_valid_q;
assign rx_fire    = i_rx_valid && o_rx_ready;
assign msg_fire   = msg_valid_q && i_msg_ready;

assign f_syn = i_rx_flags[tcp_pkg::FLAG_SYN];
assign f_ack = i_rx_flags[tcp_pkg::FLAG_ACK];
assign f_fin = i_rx_flags[tcp_pkg::FLAG_FIN];
assign f_rst = i_rx_flags[tcp_pkg::FLAG_RST];

assign ack_ok = (i_rx_ack == i_snd_nxt);
assign seq_ok = (i_rx_seq == rcv_nxt_q);

assign o_msg       = msg_q;
assign o_msg_valid = msg_valid_q;
assign o_rcv_nxt   = rcv_nxt_q;

always_comb begin
    if (f_rst) begin
        msg_d = tcp_pkg::MSG_RST;
    end else if (f_syn && f_ack && ack_ok) begin
        msg_d = tcp_pkg::MSG_SYNACK;
    end else if (f_fin && !f_syn && ack_ok && seq_ok) begin
        msg_d = tcp_pkg::MSG_FIN;
    end else if (f_ack && !f_syn && !f_fin && ack_ok) begin
        msg_d = tcp_pkg::MSG_ACK;
    end else begin
        msg_d = tcp_pkg::MSG_BAD;
    end
end

always_ff @(posedge i_clk) begin
    if (i_rst) begin
        msg_valid_q <= 1'b0;
        rcv_nxt_q   <= '0;
    end else if (rx_fire) begin
        msg_valid_q <= 1'b1;
        // SYN and in-order FIN each occupy one sequence number
        if (msg_d == tcp_pkg::MSG_SYNACK) begin
            rcv_nxt_q <= i_rx_seq + 32'd1;
        end else if (msg_d == tcp_pkg::MSG_FIN) begin
            rcv_nxt_q <= rcv_nxt_q + 32'd1;
        end
    end else if (msg_fire) begin
        msg_valid_q <= 1'b0;
    end
end

always_ff @(posedge i_clk) begin
    if (rx_fire) begin
        msg_q <= msg_d;
    end
end

endmodule

`default_nettype wire

/* verilog/tcp_state_manager.sv */
`timescale 1ns/1ps
`default_nettype none

module tcp_state_manager (
    input  wire                      i_clk,
    input  wire                      i_rst,

    input  wire                      i_enable,
    input  wire                      i_open,
    input  wire                      i_close,

    input  wire tcp_pkg::rx_msg_t    i_msg,
    input  wire                      i_msg_valid,
    output logic                     o_msg_ready,

    output tcp_pkg::tx_req_t         o_req,
    output logic                     o_req_valid,
    input  wire                      i_req_ready,

    output tcp_pkg::tcp_state_t      o_state
);

tcp_pkg::tcp_state_t state_q;
tcp_pkg::tcp_state_t state_d;

tcp_pkg::tx_req_t req_q;
tcp_pkg::tx_req_t req_d;
logic req_valid_q;
logic req_set;

logic [tcp_pkg::TW_CNT_W-1:0] tw_cnt;
logic msg_fire;

// no new message while a request is still waiting
assign o_msg_ready = !req_valid_q;
assign msg_fire    = i_msg_valid && o_msg_ready;

assign o_req       = req_q;
assign o_req_valid = req_valid_q;
assign o_state     = state_q;

always_comb begin
    state_d = state_q;
    req_d   = tcp_pkg::TX_ACK;
    req_set = 1'b0;

    if (!i_enable) begin
        state_d = tcp_pkg::ST_CLOSED;
    end else if (msg_fire && i_msg == tcp_pkg::MSG_RST) begin
        state_d = tcp_pkg::ST_CLOSED;
    end else if (state_q == tcp_pkg::ST_TIME_WAIT) begin
        // timer runs even if the last ACK is still queued
        if (tw_cnt == tcp_pkg::TW_LAST) begin
            state_d = tcp_pkg::ST_CLOSED;
        end
    end else if (!req_valid_q) begin
        case (state_q)
            tcp_pkg::ST_CLOSED: begin
                if (i_open) begin
                    state_d = tcp_pkg::ST_SYN_SENT;
                    req_d   = tcp_pkg::TX_SYN;
                    req_set = 1'b1;
                end
            end
            tcp_pkg::ST_SYN_SENT: begin
                if (msg_fire && i_msg == tcp_pkg::MSG_SYNACK) begin
                    state_d = tcp_pkg::ST_ESTABLISHED;
                    req_d   = tcp_pkg::TX_ACK;
                    req_set = 1'b1;
                end
            end
            tcp_pkg::ST_ESTABLISHED: begin
                // peer FIN wins over a local close in the same cycle
                if (msg_fire && i_msg == tcp_pkg::MSG_FIN) begin
                    state_d = tcp_pkg::ST_LAST_ACK;
                    req_d   = tcp_pkg::TX_FIN;
                    req_set = 1'b1;
                end else if (i_close) begin
                    state_d = tcp_pkg::ST_FIN_WAIT_1;
                    req_d   = tcp_pkg::TX_FIN;
                    req_set = 1'b1;
                end
            end
            tcp_pkg::ST_FIN_WAIT_1: begin
                if (msg_fire && i_msg == tcp_pkg::MSG_ACK) begin
                    state_d = tcp_pkg::ST_FIN_WAIT_2;
                end
            end
            tcp_pkg::ST_FIN_WAIT_2: begin
                if (msg_fire && i_msg == tcp_pkg::MSG_FIN) begin
                    state_d = tcp_pkg::ST_TIME_WAIT;
                    req_d   = tcp_pkg::TX_ACK;
                    req_set = 1'b1;
                end
            end
            tcp_pkg::ST_LAST_ACK: begin
                if (msg_fire && i_msg == tcp_pkg::MSG_ACK) begin
                    state_d = tcp_pkg::ST_CLOSED;
                end
            end
            default: begin
                state_d = tcp_pkg::ST_CLOSED;
            end
        endcase
    end
end

always_ff @(posedge i_clk) begin
    if (i_rst) begin
        state_q     <= tcp_pkg::ST_CLOSED;
        req_valid_q <= 1'b0;
        tw_cnt      <= '0;
    end else begin
        state_q <= state_d;

        if (!i_enable) begin
            req_valid_q <= 1'b0;
        end else if (req_set) begin
            req_valid_q <= 1'b1;
        end else if (i_req_ready) begin
            req_valid_q <= 1'b0;
        end

        if (state_q == tcp_pkg::ST_TIME_WAIT) begin
            tw_cnt <= tw_cnt + 1'b1;
        end else begin
            tw_cnt <= '0;
        end
    end
end

always_ff @(posedge i_clk) begin
    if (req_set) begin
        req_q <= req_d;
    end
end

endmodule

`default_nettype wire

/* verilog/tcp_stream.sv */
`timescale 1ns/1ps
`default_nettype none

module tcp_stream (
    input  wire                  i_clk,
    input  wire                  i_rst,

    input  wire                  i_enable,
    input  wire                  i_open,
    input  wire                  i_close,
    input  wire [15:0]           i_src_port,
    input  wire [15:0]           i_dst_port,
    input  wire [31:0]           i_isn,

    input  wire                  i_rx_valid,
    output logic                 o_rx_ready,
    input  wire [31:0]           i_rx_seq,
    input  wire [31:0]           i_rx_ack,
    input  wire [7:0]            i_rx_flags,
    input  wire [15:0]           i_rx_window,

    output logic                 o_tx_valid,
    input  wire                  i_tx_ready,
    output logic [15:0]          o_tx_src_port,
    output logic [15:0]          o_tx_dst_port,
    output logic [31:0]          o_tx_seq,
    output logic [31:0]          o_tx_ack,
    output logic [7:0]           o_tx_flags,
    output logic [15:0]          o_tx_window,

    output tcp_pkg::tcp_state_t  o_state
);

tcp_pkg::rx_msg_t msg;
logic             msg_valid;
logic             msg_ready;

tcp_pkg::tx_req_t req;
logic             req_valid;
logic             req_ready;

logic [31:0]      hdr_seq;
logic [7:0]       hdr_flags;
logic             hdr_valid;
logic             hdr_ready;

logic [31:0]      snd_nxt;
logic [31:0]      rcv_nxt;

// connection fsm
tcp_state_manager u_tcp_state_manager (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_enable       (i_enable),
    .i_open         (i_open),
    .i_close        (i_close),
    .i_msg          (msg),
    .i_msg_valid    (msg_valid),
    .o_msg_ready    (msg_ready),
    .o_req          (req),
    .o_req_valid    (req_valid),
    .i_req_ready    (req_ready),
    .o_state        (o_state)
);

// send side
tcp_tx_ctrl u_tcp_tx_ctrl (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_isn          (i_isn),
    .i_req          (req),
    .i_req_valid    (req_valid),
    .o_req_ready    (req_ready),
    .o_seq          (hdr_seq),
    .o_flags        (hdr_flags),
    .o_hdr_valid    (hdr_valid),
    .i_hdr_ready    (hdr_ready),
    .o_snd_nxt      (snd_nxt)
);

// receive side
tcp_rx_ctrl u_tcp_rx_ctrl (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_rx_seq       (i_rx_seq),
    .i_rx_ack       (i_rx_ack),
    .i_rx_flags     (i_rx_flags),
    .i_rx_window    (i_rx_window),
    .i_rx_valid     (i_rx_valid),
    .o_rx_ready     (o_rx_ready),
    .i_snd_nxt      (snd_nxt),
    .o_msg          (msg),
    .o_msg_valid    (msg_valid),
    .i_msg_ready    (msg_ready),
    .o_rcv_nxt      (rcv_nxt)
);

// outgoing header register
tcp_hdr_gen u_tcp_hdr_gen (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_src_port     (i_src_port),
    .i_dst_port     (i_dst_port),
    .i_seq          (hdr_seq),
    .i_flags        (hdr_flags),
    .i_hdr_valid    (hdr_valid),
    .o_hdr_ready    (hdr_ready),
    .i_rcv_nxt      (rcv_nxt),
    .o_tx_src_port  (o_tx_src_port),
    .o_tx_dst_port  (o_tx_dst_port),
    .o_tx_seq       (o_tx_seq),
    .o_tx_ack       (o_tx_ack),
    .o_tx_flags     (o_tx_flags),
    .o_tx_window    (o_tx_window),
    .o_tx_valid     (o_tx_valid),
    .i_tx_ready     (i_tx_ready)
);

endmodule

`default_nettype wire

/* verilog/tcp_tx_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module tcp_tx_ctrl (
    input  wire                      i_clk,
    input  wire                      i_rst,

    input  wire [31:0]               i_isn,

    input  wire tcp_pkg::tx_req_t    i_req,
    input  wire                      i_req_valid,
    output logic                     o_req_ready,

    output logic [31:0]              o_seq,
    output logic [7:0]               o_flags,
    output logic                     o_hdr_valid,
    input  wire                      i_hdr_ready,

    output logic [31:0]              o_snd_nxt
);

logic [31:0] snd_nxt_q;
logic [31:0] seq_q;
logic [7:0]  flags_q;
logic        hdr_valid_q;

logic        req_fire;
logic        hdr_fire;
logic [7:0]  req_flags;
logic        consumes_seq;

// one header slot, request taken only when it is free
assign o_req_ready = !hdr_valid_q;
assign req_fire    = i_req_valid && o_req_ready;
assign hdr_fire    = hdr_valid_q && i_hdr_ready;

assign consumes_seq = flags_q[tcp_pkg::FLAG_SYN] | flags_q[tcp_pkg::FLAG_FIN];

assign o_seq       = seq_q;
assign o_flags     = flags_q;
assign o_hdr_valid = hdr_valid_q;
assign o_snd_nxt   = snd_nxt_q;

always_comb begin
    req_flags = '0;
    case (i_req)
        tcp_pkg::TX_SYN: begin
            req_flags[tcp_pkg::FLAG_SYN] = 1'b1;
        end
        tcp_pkg::TX_FIN: begin
            req_flags[tcp_pkg::FLAG_FIN] = 1'b1;
            req_flags[tcp_pkg::FLAG_ACK] = 1'b1;
        end
        default: begin
            req_flags[tcp_pkg::FLAG_ACK] = 1'b1;
        end
    endcase
end

always_ff @(posedge i_clk) begin
    if (i_rst) begin
        hdr_valid_q <= 1'b0;
        snd_nxt_q   <= '0;
    end else if (req_fire) begin
        hdr_valid_q <= 1'b1;
        if (i_req == tcp_pkg::TX_SYN) begin
            snd_nxt_q <= i_isn;
        end
    end else if (hdr_fire) begin
        hdr_valid_q <= 1'b0;
        // SYN and FIN each take one sequence number
        if (consumes_seq) begin
            snd_nxt_q <= snd_nxt_q + 32'd1;
        end
    end
end

always_ff @(posedge i_clk) begin
    if (req_fire) begin
        seq_q   <= (i_req == tcp_pkg::TX_SYN) ? i_isn : snd_nxt_q;
        flags_q <= req_flags;
    end
end

endmodule

`default_nettype wire
